/* addr_gen.sv */
`timescale 1ns/1ns

module addr_gen
    import rrag_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    operand_read_if.user         gpr,
    operand_read_if.user         seg,
    input  logic                 valid_in,
    input  logic                 use_base,
    input  logic                 use_index,
    input  logic                 mem1_use,
    input  logic                 mem2_use,
    input  logic                 is_rep,
    input  logic                 addr_mode,     // 1 for 32-bit addressing, 0 for 16-bit
    input  logic                 fwd_stall,
    input  logic [1:0]           scale,
    input  logic [ADDR_W-1:0]    disp,
    input  opsize_t              opsize,
    input  logic                 dest_en,
    input  logic                 seg_dest_en,
    input  logic [REG_IDX_W-1:0] dest_addr,
    input  logic [REG_IDX_W-1:0] seg_dest_addr,
    output logic                 stall,
    output logic                 valid_out,
    output logic [ADDR_W-1:0]    mem_addr1,
    output logic [ADDR_W-1:0]    mem_addr1_end,
    output logic [ADDR_W-1:0]    mem_addr2,
    output logic [ADDR_W-1:0]    rep_num,
    output opsize_t              opsize_out,
    output logic                 is_rep_out
);

    logic        mem1_busy;
    logic        mem2_busy;
    logic        accept;
    gpr_t        base_val;
    gpr_t        index_val;
    gpr_t        offset_full;
    gpr_t        offset;
    gpr_t        seg1_base;
    gpr_t        seg2_base;
    gpr_t        addr1;
    gpr_t        addr1_end;
    gpr_t        addr2;
    gpr_t        rep_val;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stall and acceptance
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // segment read port 0 serves the first access, port 1 the second
    assign mem1_busy = (use_base && gpr.rd_busy[RD_BASE])
                     || (use_index && gpr.rd_busy[RD_INDEX])
                     || seg.rd_busy[0];
    assign mem2_busy = gpr.rd_busy[RD_PTR] || seg.rd_busy[1];

    assign stall = fwd_stall
                 || (mem1_use && mem1_busy)
                 || (mem2_use && mem2_busy)
                 || (is_rep && gpr.rd_busy[RD_PTR]);   // count register still in flight

    assign accept = valid_in && !stall;

    assign gpr.mark_en   = accept && dest_en;
    assign gpr.mark_addr = dest_addr;
    assign seg.mark_en   = accept && seg_dest_en;
    assign seg.mark_addr = seg_dest_addr;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // address arithmetic
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        base_val    = use_base ? gpr.rd_data[RD_BASE] : '0;
        index_val   = use_index ? (gpr.rd_data[RD_INDEX] << scale) : '0;
        offset_full = base_val + index_val + disp;
        offset      = addr_mode ? offset_full : {16'h0000, offset_full[15:0]};

        seg1_base = {{(ADDR_W - SEG_W - SEG_SHIFT){1'b0}}, seg.rd_data[0], {SEG_SHIFT{1'b0}}};
        seg2_base = {{(ADDR_W - SEG_W - SEG_SHIFT){1'b0}}, seg.rd_data[1], {SEG_SHIFT{1'b0}}};

        addr1     = seg1_base + offset;                       // wraps at 2^32
        addr1_end = addr1 + opsize_bytes(opsize) - 32'd1;
        addr2     = seg2_base + gpr.rd_data[RD_PTR];
        rep_val   = is_rep ? gpr.rd_data[RD_PTR] : '0;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // output stage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_out     <= 1'b0;
            mem_addr1     <= '0;
            mem_addr1_end <= '0;
            mem_addr2     <= '0;
            rep_num       <= '0;
            opsize_out    <= SZ_1;
            is_rep_out    <= 1'b0;
        end else begin
            valid_out <= accept;
            // hold the last accepted instruction while nothing new is taken
            if (accept) begin
                mem_addr1     <= addr1;
                mem_addr1_end <= addr1_end;
                mem_addr2     <= addr2;
                rep_num       <= rep_val;
                opsize_out    <= opsize;
                is_rep_out    <= is_rep;
            end
        end
    end

endmodule

/* operand_file.sv */
`timescale 1ns/1ns

module operand_file
    import rrag_pkg::*;
#(
    parameter type T      = logic,
    parameter int  N_RD   = 1,
    parameter int  N_WB   = 1,
    parameter int  N_REGS = 8
) (
    input  logic                 clk,
    input  logic                 rst,
    operand_read_if.file         rd,
    input  logic [N_WB-1:0]      wb_en,
    input  logic [REG_IDX_W-1:0] wb_addr [N_WB],
    input  T                     wb_data [N_WB]
);

    T                  regs [N_REGS];
    logic [N_REGS-1:0] busy;   // one pending bit per register

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // register values
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < N_REGS; r++) begin
                regs[r] <= '0;
            end
        end else begin
            // ports are walked in order so the highest numbered port lands last
            for (int p = 0; p < N_WB; p++) begin
                if (wb_en[p]) begin
                    regs[wb_addr[p]] <= wb_data[p];
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // pending bits
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (rst) begin
            busy <= '0;
        end else begin
            for (int p = 0; p < N_WB; p++) begin
                if (wb_en[p]) begin
                    busy[wb_addr[p]] <= 1'b0;   // result has arrived
                end
            end
            // a new producer for the same register keeps it pending
            if (rd.mark_en) begin
                busy[rd.mark_addr] <= 1'b1;
            end
        end
    end

    // reads see only what was stored at the last edge
    for (genvar i = 0; i < N_RD; i++) begin : g_rd
        assign rd.rd_data[i] = regs[rd.rd_addr[i]];
        assign rd.rd_busy[i] = busy[rd.rd_addr[i]];
    end

endmodule

/* rrag.f */
rrag_pkg.sv
rrag_if.sv
operand_file.sv
addr_gen.sv
rrag.sv
tb_rrag.sv

/* rrag.sv */
`timescale 1ns/1ns

module rrag
    import rrag_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,

    // decoded instruction
    input  logic                 valid_in,
    input  logic [REG_IDX_W-1:0] base_addr,
    input  logic [REG_IDX_W-1:0] index_addr,
    input  logic [REG_IDX_W-1:0] ptr_addr,
    input  logic [REG_IDX_W-1:0] seg1_addr,
    input  logic [REG_IDX_W-1:0] seg2_addr,
    input  logic                 use_base,
    input  logic                 use_index,
    input  logic                 mem1_use,
    input  logic                 mem2_use,
    input  logic                 is_rep,
    input  logic                 addr_mode,
    input  logic                 fwd_stall,
    input  logic [1:0]           scale,
    input  logic [ADDR_W-1:0]    disp,
    input  opsize_t              opsize,
    input  logic                 dest_en,
    input  logic                 seg_dest_en,
    input  logic [REG_IDX_W-1:0] dest_addr,
    input  logic [REG_IDX_W-1:0] seg_dest_addr,

    // writeback
    input  logic [1:0]           wb_en,
    input  logic [REG_IDX_W-1:0] wb_addr0,
    input  logic [REG_IDX_W-1:0] wb_addr1,
    input  gpr_t                 wb_data0,
    input  gpr_t                 wb_data1,
    input  logic                 wb_seg_en,
    input  logic [REG_IDX_W-1:0] wb_seg_addr,
    input  seg_t                 wb_seg_data,

    output logic                 stall,
    output logic                 valid_out,
    output logic [ADDR_W-1:0]    mem_addr1,
    output logic [ADDR_W-1:0]    mem_addr1_end,
    output logic [ADDR_W-1:0]    mem_addr2,
    output logic [ADDR_W-1:0]    rep_num,
    output opsize_t              opsize_out,
    output logic                 is_rep_out
);

    operand_read_if #(.T(gpr_t), .N(NUM_RD_GPR)) gpr_rd ();
    operand_read_if #(.T(seg_t), .N(NUM_RD_SEG)) seg_rd ();

    logic [REG_IDX_W-1:0] gpr_wb_addr [NUM_WB_GPR];
    gpr_t                 gpr_wb_data [NUM_WB_GPR];
    logic [REG_IDX_W-1:0] seg_wb_addr [NUM_WB_SEG];
    seg_t                 seg_wb_data [NUM_WB_SEG];

    assign gpr_rd.rd_addr[RD_BASE]  = base_addr;
    assign gpr_rd.rd_addr[RD_INDEX] = index_addr;
    assign gpr_rd.rd_addr[RD_PTR]   = ptr_addr;
    assign seg_rd.rd_addr[0]        = seg1_addr;
    assign seg_rd.rd_addr[1]        = seg2_addr;

    // port 1 is the higher priority writer
    assign gpr_wb_addr[0] = wb_addr0;
    assign gpr_wb_addr[1] = wb_addr1;
    assign gpr_wb_data[0] = wb_data0;
    assign gpr_wb_data[1] = wb_data1;
    assign seg_wb_addr[0] = wb_seg_addr;
    assign seg_wb_data[0] = wb_seg_data;

    operand_file #(
        .T      (gpr_t),
        .N_RD   (NUM_RD_GPR),
        .N_WB   (NUM_WB_GPR),
        .N_REGS (NUM_GPR)
    ) u_gpr (
        .clk     (clk),
        .rst     (rst),
        .rd      (gpr_rd.file),
        .wb_en   (wb_en),
        .wb_addr (gpr_wb_addr),
        .wb_data (gpr_wb_data)
    );

    operand_file #(
        .T      (seg_t),
        .N_RD   (NUM_RD_SEG),
        .N_WB   (NUM_WB_SEG),
        .N_REGS (NUM_SEG)
    ) u_seg (
        .clk     (clk),
        .rst     (rst),
        .rd      (seg_rd.file),
        .wb_en   (wb_seg_en),
        .wb_addr (seg_wb_addr),
        .wb_data (seg_wb_data)
    );

    addr_gen u_agen (
        .clk           (clk),
        .rst           (rst),
        .gpr           (gpr_rd.user),
        .seg           (seg_rd.user),
        .valid_in      (valid_in),
        .use_base      (use_base),
        .use_index     (use_index),
        .mem1_use      (mem1_use),
        .mem2_use      (mem2_use),
        .is_rep        (is_rep),
        .addr_mode     (addr_mode),
        .fwd_stall     (fwd_stall),
        .scale         (scale),
        .disp          (disp),
        .opsize        (opsize),
        .dest_en       (dest_en),
        .seg_dest_en   (seg_dest_en),
        .dest_addr     (dest_addr),
        .seg_dest_addr (seg_dest_addr),
        .stall         (stall),
        .valid_out     (valid_out),
        .mem_addr1     (mem_addr1),
        .mem_addr1_end (mem_addr1_end),
        .mem_addr2     (mem_addr2),
        .rep_num       (rep_num),
        .opsize_out    (opsize_out),
        .is_rep_out    (is_rep_out)
    );

endmodule

/* rrag_if.sv */
`timescale 1ns/1ns

// one operand file's read ports plus the mark that sets a pending bit
interface operand_read_if
    import rrag_pkg::*;
#(
    parameter type T = logic,
    parameter int  N = 1
) ();

    // read side, one entry per port
    logic [REG_IDX_W-1:0] rd_addr [N];
    T                     rd_data [N];
    logic [N-1:0]         rd_busy;      // pending bit of the addressed register

    // an accepted instruction names this register as a destination
    logic                 mark_en;
    logic [REG_IDX_W-1:0] mark_addr;

    // the register array side
    modport file (
        input  rd_addr,
        input  mark_en,
        input  mark_addr,
        output rd_data,
        output rd_busy
    );

    // the side that consumes operands and issues marks
    modport user (
        output rd_addr,
        output mark_en,
        output mark_addr,
        input  rd_data,
        input  rd_busy
    );

endinterface

/* rrag_pkg.sv */
package rrag_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // widths and register counts
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int ADDR_W     = 32;  // address and general register width
    localparam int SEG_W      = 16;
    localparam int SEG_SHIFT  = 4;   // real-mode style segment base
    localparam int NUM_GPR    = 8;
    localparam int NUM_SEG    = 8;
    localparam int REG_IDX_W  = 3;

    localparam int NUM_WB_GPR = 2;
    localparam int NUM_WB_SEG = 1;
    localparam int NUM_RD_GPR = 3;
    localparam int NUM_RD_SEG = 2;

    // general read ports in the order the top level wires them
    localparam int RD_BASE    = 0;
    localparam int RD_INDEX   = 1;
    localparam int RD_PTR     = 2;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // payloads and encodings
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef logic [ADDR_W-1:0] gpr_t;
    typedef logic [SEG_W-1:0]  seg_t;

    typedef enum logic [1:0] {
        SZ_1 = 2'd0,
        SZ_2 = 2'd1,
        SZ_4 = 2'd2,
        SZ_8 = 2'd3
    } opsize_t;

    // access length in bytes for one opsize code
    function automatic logic [ADDR_W-1:0] opsize_bytes(opsize_t sz);
        logic [ADDR_W-1:0] len;
        case (sz)
            SZ_1:    len = 32'd1;
            SZ_2:    len = 32'd2;
            SZ_4:    len = 32'd4;
            default: len = 32'd8;
        endcase
        return len;
    endfunction

endpackage

/* run_sim.sh */
#!/bin/sh
# Builds the rrag testbench with Verilator, runs it and scans the log.

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert \
    --top-module tb_rrag \
    -f rrag.f \
    -o sim_rrag > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
    cat "$BUILD_LOG"
    echo "verilator build did not complete, see $BUILD_LOG"
    exit 1
fi

./obj_dir/sim_rrag > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "test failed" "$SIM_LOG"; then
    echo "simulation reported a failure, see $SIM_LOG"
    exit 1
fi

echo "simulation clean, log in $SIM_LOG"
exit 0

/* tb_rrag.sv */
`timescale 1ns/1ns

module tb_rrag
    import rrag_pkg::*;
();

    localparam int RESET_CYCLES = 5;
    localparam int ACCEPT_LIMIT = 16;   // cycles an instruction may wait for acceptance
    localparam int TEST_CYCLES  = 40 + 60 + 60 + 20 + 20 + 10;
    localparam int WATCHDOG_CYCLES = (RESET_CYCLES + TEST_CYCLES) * 2;

    logic clk, rst;
    logic valid_in, use_base, use_index, mem1_use, mem2_use, is_rep, addr_mode, fwd_stall;
    logic [REG_IDX_W-1:0] base_addr, index_addr, ptr_addr, seg1_addr, seg2_addr;
    logic [1:0]           scale;
    logic [ADDR_W-1:0]    disp;
    opsize_t              opsize;
    logic                 dest_en, seg_dest_en;
    logic [REG_IDX_W-1:0] dest_addr, seg_dest_addr;
    logic [1:0]           wb_en;
    logic [REG_IDX_W-1:0] wb_addr0, wb_addr1, wb_seg_addr;
    gpr_t                 wb_data0, wb_data1;
    logic                 wb_seg_en;
    seg_t                 wb_seg_data;
    logic                 stall, valid_out, is_rep_out;
    logic [ADDR_W-1:0]    mem_addr1, mem_addr1_end, mem_addr2, rep_num;
    opsize_t              opsize_out;

    int err_count = 0;

    // reference state and expected outputs
    gpr_t              m_gpr [NUM_GPR];
    seg_t              m_seg [NUM_SEG];
    logic [NUM_GPR-1:0] m_gbusy;
    logic [NUM_SEG-1:0] m_sbusy;
    logic              e_stall, e_accept;
    gpr_t              e_off, e_addr1, e_end, e_addr2, e_rep;
    logic              exp_valid, exp_rep_out;
    gpr_t              exp_addr1, exp_end, exp_addr2, exp_rep;
    opsize_t           exp_opsize;

    rrag DUT (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        e_stall = fwd_stall
                || (mem1_use && ((use_base && m_gbusy[base_addr])
                                 || (use_index && m_gbusy[index_addr])
                                 || m_sbusy[seg1_addr]))
                || (mem2_use && (m_gbusy[ptr_addr] || m_sbusy[seg2_addr]))
                || (is_rep && m_gbusy[ptr_addr]);
        e_accept = valid_in && !e_stall;
        e_off = (use_base ? m_gpr[base_addr] : 32'h0)
              + (use_index ? m_gpr[index_addr] * (32'd1 << scale) : 32'h0) + disp;
        if (!addr_mode)
            e_off = e_off & 32'h0000_ffff;   // 16-bit addressing wraps the offset
        e_addr1 = 32'(m_seg[seg1_addr]) * 32'd16 + e_off;
        e_end   = e_addr1 + (32'd1 << opsize) - 32'd1;
        e_addr2 = 32'(m_seg[seg2_addr]) * 32'd16 + m_gpr[ptr_addr];
        e_rep   = is_rep ? m_gpr[ptr_addr] : 32'h0;
    end

    always @(posedge clk) begin
        if (rst) begin
            for (int r = 0; r < NUM_GPR; r++) begin
                m_gpr[r] <= '0;
            end
            for (int r = 0; r < NUM_SEG; r++) begin
                m_seg[r] <= '0;
            end
            m_gbusy     <= '0;
            m_sbusy     <= '0;
            exp_valid   <= 1'b0;
            exp_addr1   <= '0;
            exp_end     <= '0;
            exp_addr2   <= '0;
            exp_rep     <= '0;
            exp_opsize  <= SZ_1;
            exp_rep_out <= 1'b0;
        end else begin
            if (wb_en[0]) begin
                m_gpr[wb_addr0]   <= wb_data0;
                m_gbusy[wb_addr0] <= 1'b0;
            end
            if (wb_en[1]) begin   // later assignment gives port 1 the last word
                m_gpr[wb_addr1]   <= wb_data1;
                m_gbusy[wb_addr1] <= 1'b0;
            end
            if (wb_seg_en) begin
                m_seg[wb_seg_addr]   <= wb_seg_data;
                m_sbusy[wb_seg_addr] <= 1'b0;
            end
            if (e_accept && dest_en)
                m_gbusy[dest_addr] <= 1'b1;
            if (e_accept && seg_dest_en)
                m_sbusy[seg_dest_addr] <= 1'b1;
            exp_valid <= e_accept;
            if (e_accept) begin
                exp_addr1   <= e_addr1;
                exp_end     <= e_end;
                exp_addr2   <= e_addr2;
                exp_rep     <= e_rep;
                exp_opsize  <= opsize;
                exp_rep_out <= is_rep;
            end
        end
    end

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] got);
        $display("[FAIL] %s expected %h got %h at %0t", name, exp, got, $time);
        err_count++;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks sample mid-cycle where every input and output has settled
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    a_stall: assert property (@(negedge clk) disable iff (rst) stall == e_stall)
        else report_mismatch("stall", {31'h0, e_stall}, {31'h0, stall});
    a_valid: assert property (@(negedge clk) disable iff (rst) valid_out == exp_valid)
        else report_mismatch("valid_out", {31'h0, exp_valid}, {31'h0, valid_out});
    a_addr1: assert property (@(negedge clk) disable iff (rst) mem_addr1 == exp_addr1)
        else report_mismatch("mem_addr1", exp_addr1, mem_addr1);
    a_end: assert property (@(negedge clk) disable iff (rst) mem_addr1_end == exp_end)
        else report_mismatch("mem_addr1_end", exp_end, mem_addr1_end);
    a_addr2: assert property (@(negedge clk) disable iff (rst) mem_addr2 == exp_addr2)
        else report_mismatch("mem_addr2", exp_addr2, mem_addr2);
    a_rep: assert property (@(negedge clk) disable iff (rst) rep_num == exp_rep)
        else report_mismatch("rep_num", exp_rep, rep_num);
    a_size: assert property (@(negedge clk) disable iff (rst) opsize_out == exp_opsize)
        else report_mismatch("opsize_out", {30'h0, exp_opsize}, {30'h0, opsize_out});
    a_rep_out: assert property (@(negedge clk) disable iff (rst) is_rep_out == exp_rep_out)
        else report_mismatch("is_rep_out", {31'h0, exp_rep_out}, {31'h0, is_rep_out});

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    function automatic logic [2:0] rand_idx();
        logic [31:0] v;
        v = $urandom;
        return v[2:0];
    endfunction

    function automatic logic rand_bit();
        logic [31:0] v;
        v = $urandom;
        return v[0];
    endfunction

    function automatic logic [15:0] rand_half();
        logic [31:0] v;
        v = $urandom;
        return v[15:0];
    endfunction

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic clear_inputs();
        valid_in = 1'b0;
        {use_base, use_index, mem1_use, mem2_use, is_rep, fwd_stall} = '0;
        addr_mode = 1'b1;
        {base_addr, index_addr, ptr_addr, seg1_addr, seg2_addr} = '0;
        scale = 2'd0;
        disp = '0;
        opsize = SZ_1;
        {dest_en, seg_dest_en, dest_addr, seg_dest_addr} = '0;
    endtask

    // every register gets a fresh value while the general ports take turns
    task automatic load_all_regs();
        for (int r = 0; r < NUM_GPR; r++) begin
            if (r % 2 == 0) begin
                wb_en = 2'b01;
                wb_addr0 = r[2:0];
                wb_data0 = $urandom;
            end else begin
                wb_en = 2'b10;
                wb_addr1 = r[2:0];
                wb_data1 = $urandom;
            end
            wb_seg_en = 1'b1;
            wb_seg_addr = r[2:0];
            wb_seg_data = rand_half();
            step();
        end
        wb_en = 2'b00;
        wb_seg_en = 1'b0;
    endtask

    // holds valid_in until the DUT drops stall, then lets it go
    task automatic issue();
        int waited;
        waited = 0;
        valid_in = 1'b1;
        @(negedge clk);
        while (stall && waited < ACCEPT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (stall) begin
            $display("instruction still stalled after %0d cycles at %0t", waited, $time);
            err_count++;
        end
        @(posedge clk);
        #1;
        valid_in = 1'b0;
        dest_en = 1'b0;
        seg_dest_en = 1'b0;
    endtask

    task automatic hazard(input int kind);
        logic [2:0] r;
        r = rand_idx();
        clear_inputs();
        if (kind >= 4) begin
            seg_dest_en = 1'b1;
            seg_dest_addr = r;
        end else begin
            dest_en = 1'b1;
            dest_addr = r;
        end
        issue();
        clear_inputs();
        case (kind)
            0: begin
                mem1_use = 1'b1;
                use_base = 1'b1;
                base_addr = r;
            end
            1: begin
                mem1_use = 1'b1;
                use_index = 1'b1;
                index_addr = r;
                scale = 2'd1;
            end
            2: begin
                mem2_use = 1'b1;
                ptr_addr = r;
            end
            3: begin
                is_rep = 1'b1;
                ptr_addr = r;
            end
            4: begin
                mem1_use = 1'b1;
                seg1_addr = r;
            end
            default: begin
                mem2_use = 1'b1;
                seg2_addr = r;
            end
        endcase
        valid_in = 1'b1;
        repeat (3) step();   // held while the producer is in flight
        if (kind >= 4) begin
            wb_seg_en = 1'b1;
            wb_seg_addr = r;
            wb_seg_data = rand_half();
        end else begin
            wb_en = 2'b01;
            wb_addr0 = r;
            wb_data0 = $urandom;
        end
        step();
        wb_en = 2'b00;
        wb_seg_en = 1'b0;
        issue();
    endtask

    task automatic report_test(input int num, input string name, input int errs_before);
        $display("test %0d %s done with %0d errors", num, name, err_count - errs_before);
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
        $display("test failed");
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // test sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        int errs;
        logic [2:0] r;
        void'($urandom(89422));
        rst = 1'b1;
        clear_inputs();
        wb_en = 2'b00;
        {wb_addr0, wb_addr1, wb_data0, wb_data1} = '0;
        {wb_seg_en, wb_seg_addr, wb_seg_data} = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;

        errs = err_count;
        load_all_regs();
        for (int i = 0; i < NUM_GPR; i++) begin
            clear_inputs();
            {mem1_use, use_base, mem2_use} = 3'b111;
            {base_addr, seg1_addr, seg2_addr, ptr_addr} = {4{i[2:0]}};
            issue();
            clear_inputs();
            {mem1_use, use_index} = 2'b11;
            {index_addr, seg1_addr} = {2{i[2:0]}};
            scale = i[1:0];
            issue();
        end
        report_test(1, "reset_and_readback", errs);

        errs = err_count;
        load_all_regs();
        for (int i = 0; i < 40; i++) begin
            clear_inputs();
            {base_addr, index_addr, ptr_addr} = {rand_idx(), rand_idx(), rand_idx()};
            {seg1_addr, seg2_addr} = {rand_idx(), rand_idx()};
            {use_base, use_index, mem2_use} = {rand_bit(), rand_bit(), rand_bit()};
            {is_rep, addr_mode} = {rand_bit(), rand_bit()};
            mem1_use = 1'b1;
            scale = {rand_bit(), rand_bit()};
            disp = $urandom;
            opsize = opsize_t'(i[1:0]);   // every access length in turn
            issue();
        end
        report_test(2, "effective_address", errs);

        errs = err_count;
        for (int k = 0; k < 6; k++)
            hazard(k);
        r = rand_idx();
        clear_inputs();
        {dest_en, seg_dest_en} = 2'b11;
        {dest_addr, seg_dest_addr} = {r, r};
        issue();
        clear_inputs();
        mem1_use = 1'b1;
        {base_addr, index_addr, seg1_addr} = {r, r, r + 3'd1};
        issue();   // pending register named but its use flags are low
        clear_inputs();
        use_base = 1'b1;
        {base_addr, seg1_addr, ptr_addr} = {r, r, r};
        issue();   // no access at all
        wb_en = 2'b01;
        wb_addr0 = r;
        wb_seg_en = 1'b1;
        wb_seg_addr = r;
        step();
        {wb_en, wb_seg_en} = '0;
        report_test(3, "pending_marks", errs);

        errs = err_count;
        r = rand_idx();
        wb_en = 2'b11;
        {wb_addr0, wb_addr1} = {r, r};
        wb_data0 = $urandom;
        wb_data1 = $urandom;
        step();
        wb_en = 2'b00;
        clear_inputs();
        {mem1_use, use_base, base_addr} = {2'b11, r};
        issue();
        clear_inputs();
        {dest_en, dest_addr} = {1'b1, r};
        wb_en = 2'b01;
        wb_data0 = $urandom;
        issue();   // mark and writeback meet at one edge
        wb_en = 2'b00;
        clear_inputs();
        {mem1_use, use_base, base_addr} = {2'b11, r};
        valid_in = 1'b1;
        repeat (2) step();
        wb_en = 2'b10;
        step();
        wb_en = 2'b00;
        issue();
        report_test(4, "writeback_priority", errs);

        errs = err_count;
        load_all_regs();
        for (int i = 0; i < 10; i++) begin
            clear_inputs();
            {ptr_addr, seg2_addr, seg1_addr} = {rand_idx(), rand_idx(), rand_idx()};
            {mem2_use, mem1_use, is_rep} = {1'b1, rand_bit(), i[0]};
            issue();
        end
        report_test(5, "repeat_and_pointer", errs);

        errs = err_count;
        clear_inputs();
        {fwd_stall, valid_in} = 2'b11;
        repeat (3) step();
        fwd_stall = 1'b0;
        issue();
        report_test(6, "forward_stall", errs);

        $display("6 tests run, %0d checks failed", err_count);
        if (err_count == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule
